// ==== files.f ====
+incdir+include
hdl/cpu_pkg.sv
hdl/bus_pkg.sv
hdl/cpu_ifs.sv
hdl/register_bank.sv
hdl/alu.sv
hdl/instr_store.sv
hdl/control_unit.sv
hdl/apb_host_port.sv
hdl/mini_cpu.sv
bench/cpu_checker.sv
bench/tb_mini_cpu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module tb_mini_cpu -o sim_mini_cpu
./obj_dir/sim_mini_cpu > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
fi
exit 1

// ==== bench/tb_mini_cpu.sv ====
`timescale 1ns/10ps
`include "cpu_defs.svh"

module tb_mini_cpu;

  logic                       clock;
  logic                       reset;
  logic [`APB_ADDR_BITS-1:0]  paddr;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [`APB_DATA_BITS-1:0]  pwdata;
  logic [`APB_DATA_BITS-1:0]  prdata;
  logic                       pready;
  logic                       pslverr;
  int                         value_errors;  // From the checker
  int                         bus_errors;
  int                         timeouts;      // Waits that ran out
  int                         cycle_count;
  int                         prog_len;
  logic [`WORD_BITS-1:0]      program_words [`IMEM_DEPTH];

  mini_cpu mini_cpu_inst (
    .clock, .reset, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr
  );

  cpu_checker checker_inst (
    .clock, .reset, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .value_errors, .bus_errors
  );

  always #10 clock = ~clock;  // 20 ns period

  always @(posedge clock) cycle_count++;

  // One APB transfer, setup then access, inputs change on falling edges
  task automatic apb_transfer(input logic wr, input logic [`APB_ADDR_BITS-1:0] addr,
                              input logic [`APB_DATA_BITS-1:0] wdata,
                              output logic [`APB_DATA_BITS-1:0] rdata);
    int waited;
    @(negedge clock);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clock);
    penable = 1'b1;
    waited  = 0;
    @(posedge clock);
    while (!pready && waited < 16) begin  // Slave may stretch the access
      @(posedge clock);
      waited++;
    end
    if (!pready) begin
      $display("Timeout: APB transfer to 0x%h never completed", addr);
      timeouts++;
    end
    rdata = prdata;
    @(negedge clock);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_word(input logic [`APB_ADDR_BITS-1:0] addr,
                            input logic [`APB_DATA_BITS-1:0] data);
    logic [`APB_DATA_BITS-1:0] unused;
    apb_transfer(1'b1, addr, data, unused);
  endtask

  task automatic read_word(input logic [`APB_ADDR_BITS-1:0] addr,
                           output logic [`APB_DATA_BITS-1:0] data);
    apb_transfer(1'b0, addr, '0, data);
  endtask

  // Status and all eight registers, compared by the checker
  task automatic dump_registers();
    logic [`APB_DATA_BITS-1:0] data;
    read_word(8'h80, data);
    for (int r = 0; r < `NUM_REGS; r++) read_word(8'(8'hA0 + r * 4), data);
  endtask

  task automatic load_program(input int len);
    for (int i = 0; i < len; i++) write_word(8'(i * 4), {16'd0, program_words[i]});
  endtask

  // Start, then poll until busy falls
  task automatic run_and_wait();
    logic [`APB_DATA_BITS-1:0] data;
    int                        t0;
    logic                      busy;
    write_word(8'h80, 32'h1);
    t0   = cycle_count;
    busy = 1'b1;
    while (busy && (cycle_count - t0) < 200) begin
      read_word(8'h80, data);
      busy = data[0];
    end
    if (busy) begin
      $display("Timeout: core still busy 200 cycles after start");
      timeouts++;
    end
    dump_registers();
  endtask

  task automatic random_program();
    prog_len = 4 + int'($urandom_range(26, 0));  // 4 to 30 body words
    for (int i = 0; i < prog_len; i++) program_words[i] = 16'($urandom);
    program_words[prog_len] = 16'hF000;          // Trailing HALT
    load_program(prog_len + 1);
  endtask

  task automatic pulse_reset();
    @(negedge clock);
    reset = 1'b1;
    repeat (10) @(negedge clock);
    reset = 1'b0;
  endtask

  task automatic bad_accesses();
    logic [`APB_DATA_BITS-1:0] data;
    read_word(8'h84, data);     // Unmapped
    read_word(8'h90, data);
    read_word(8'hC0, data);
    read_word(8'hFC, data);
    read_word(8'hA2, data);     // Unaligned register
    read_word(8'h00, data);     // Program memory is write-only
    read_word(8'h3C, data);
    read_word(8'h7C, data);
    write_word(8'h84, 32'h1);   // Must not start the core
    write_word(8'h82, 32'h1);
    read_word(8'h80, data);     // Valid accesses stay error free
    read_word(8'hBC, data);
  endtask

  initial begin
    void'($urandom(32'h397f_fcb8));
    clock       = 1'b0;
    reset       = 1'b1;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    timeouts    = 0;
    cycle_count = 0;
    repeat (10) @(negedge clock);
    reset = 1'b0;
    dump_registers();                          // Everything zero after reset
    for (int p = 0; p < 20; p++) begin
      random_program();
      run_and_wait();
    end
    for (int i = 0; i < `IMEM_DEPTH; i++) begin
      program_words[i] = {4'($urandom_range(14, 0)), 12'($urandom)};  // No HALT
    end
    load_program(`IMEM_DEPTH);
    run_and_wait();
    bad_accesses();
    random_program();
    run_and_wait();
    pulse_reset();
    dump_registers();                          // Cleared by reset
    run_and_wait();                            // Same program, no reload
    $display("Error counts: prdata %0d, bus %0d, timeout %0d",
             value_errors, bus_errors, timeouts);
    if (value_errors == 0 && bus_errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== bench/cpu_checker.sv ====
`timescale 1ns/10ps
`include "cpu_defs.svh"

module cpu_checker (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [`APB_ADDR_BITS-1:0]  paddr,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`APB_DATA_BITS-1:0]  pwdata,
  input  logic [`APB_DATA_BITS-1:0]  prdata,
  input  logic                       pready,
  input  logic                       pslverr,
  output int                         value_errors,  // Wrong prdata
  output int                         bus_errors     // Wrong pslverr or pready
);

  logic [`WORD_BITS-1:0] imem_model [`IMEM_DEPTH];  // Mirror of host program writes
  logic [`WORD_BITS-1:0] reg_model [`NUM_REGS];     // Registers after the current run
  int                    cycle;                     // Rising edges seen
  int                    start_cycle;               // Edge that latched the start write
  int                    end_cycle;                 // Last edge with busy sampled high
  bit                    ran;                       // A run was started since reset
  bit                    prev_done;                 // done before the latest start
  bus_pkg::region_e      region;
  logic                  exp_err;
  logic [`APB_DATA_BITS-1:0] exp_data;

  initial begin
    value_errors = 0;
    bus_errors   = 0;
    cycle        = 0;
    ran          = 1'b0;
    prev_done    = 1'b0;
    for (int i = 0; i < `IMEM_DEPTH; i++) imem_model[i] = '0;
    for (int i = 0; i < `NUM_REGS; i++) reg_model[i] = '0;
  end

  // Address map from the host bus description
  function automatic bus_pkg::region_e decode(input logic [`APB_ADDR_BITS-1:0] addr);
    if (addr[1:0] != 2'b00) return bus_pkg::NONE;  // Byte offsets never map
    if (addr <= 8'h7C) return bus_pkg::IMEM;
    if (addr == 8'h80) return bus_pkg::CTRL;
    if (addr >= 8'hA0 && addr <= 8'hBC) return bus_pkg::REGS;
    return bus_pkg::NONE;
  endfunction

  // Reference ISA model, runs from word 0 to HALT or the last word
  task automatic run_program(output int steps);
    logic [`WORD_BITS-1:0] w;
    logic [`WORD_BITS-1:0] a;
    logic [`WORD_BITS-1:0] b;
    int                    pc;
    bit                    halted;
    steps  = 0;
    halted = 1'b0;
    pc     = 0;
    while (!halted && pc < `IMEM_DEPTH) begin
      w = imem_model[pc];
      a = reg_model[w[11:9]];  // Destination doubles as operand A
      b = reg_model[w[8:6]];
      steps++;
      case (w[15:12])
        4'd1:  reg_model[w[11:9]] = a + b;
        4'd2:  reg_model[w[11:9]] = a - b;
        4'd3:  reg_model[w[11:9]] = a & b;
        4'd4:  reg_model[w[11:9]] = a | b;
        4'd5:  reg_model[w[11:9]] = a ^ b;
        4'd6:  reg_model[w[11:9]] = b;
        4'd7:  reg_model[w[11:9]] = {10'd0, w[5:0]};  // Zero-extended immediate
        4'd8:  reg_model[w[11:9]] = a << 1;
        4'd15: halted = 1'b1;
        default: ;                                    // NOP and unused codes
      endcase
      pc++;
    end
  endtask

  // Status as sampled at edge t, two cycles per instruction
  function automatic logic [`APB_DATA_BITS-1:0] status_word(input int t);
    if (!ran) return '0;
    if (t == start_cycle + 1) return {30'd0, prev_done, 1'b0};  // Start not yet seen
    if (t <= end_cycle) return 32'h1;                           // busy
    return 32'h2;                                               // done
  endfunction

  task automatic start_run();
    int steps;
    prev_done   = ran;
    run_program(steps);
    start_cycle = cycle;
    end_cycle   = cycle + 2 * steps + 1;
    ran         = 1'b1;
  endtask

  always @(posedge clock) begin
    if (reset) begin
      ran       = 1'b0;
      prev_done = 1'b0;
      for (int i = 0; i < `NUM_REGS; i++) reg_model[i] = '0;  // Program memory kept
    end else if (psel && penable) begin
      if (pready !== 1'b1) begin
        $display("Error: pready expected 0x1 got 0x%h", pready);
        bus_errors++;
      end else begin
        region  = decode(paddr);
        exp_err = (region == bus_pkg::NONE) || (region == bus_pkg::IMEM && !pwrite);
        if (pslverr !== exp_err) begin
          $display("Error: pslverr at 0x%h expected 0x%h got 0x%h", paddr, exp_err, pslverr);
          bus_errors++;
        end
        if (!exp_err && pwrite) begin
          if (region == bus_pkg::IMEM) imem_model[paddr[6:2]] = pwdata[`WORD_BITS-1:0];
          if (region == bus_pkg::CTRL && pwdata[0] && (!ran || cycle >= end_cycle)) begin
            start_run();  // A start while busy is dropped
          end
        end else if (!exp_err) begin
          exp_data = status_word(cycle);
          if (region == bus_pkg::REGS) exp_data = {16'd0, reg_model[paddr[4:2]]};
          // Register values are only defined once the run is over
          if ((region == bus_pkg::CTRL || !ran || cycle > end_cycle) &&
              prdata !== exp_data) begin
            $display("Error: prdata at 0x%h expected 0x%h got 0x%h", paddr, exp_data, prdata);
            value_errors++;
          end
        end
      end
    end
    cycle++;
  end

endmodule

// ==== hdl/mini_cpu.sv ====
`timescale 1ns/10ps
`include "cpu_defs.svh"

module mini_cpu (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [`APB_ADDR_BITS-1:0]  paddr,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`APB_DATA_BITS-1:0]  pwdata,
  output logic [`APB_DATA_BITS-1:0]  prdata,
  output logic                       pready,
  output logic                       pslverr
);

  logic                        imem_we;     // Host program load
  logic [`IMEM_ADDR_BITS-1:0]  imem_waddr;
  logic [`WORD_BITS-1:0]       imem_wdata;
  logic [`IMEM_ADDR_BITS-1:0]  pc;          // Fetch address
  logic [`WORD_BITS-1:0]       instr;       // Fetched word
  logic                        start;       // Run request
  bus_pkg::status_t            status;      // busy and done
  logic [`REG_ADDR_BITS-1:0]   peek_sel;    // Inspection index
  logic [`WORD_BITS-1:0]       peek_data;

  regfile_if rf_bus ();   // Control to register bank
  alu_if     alu_bus ();  // Control to ALU

  apb_host_port host_inst (
    .clock, .reset,
    .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .imem_we, .imem_waddr, .imem_wdata,
    .start, .status, .peek_sel, .peek_data
  );

  instr_store imem_inst (
    .clock, .we(imem_we), .waddr(imem_waddr), .wdata(imem_wdata),
    .raddr(pc), .rdata(instr)
  );

  control_unit ctrl_inst (
    .clock, .reset, .start, .status, .pc, .instr,
    .rf(rf_bus.control), .au(alu_bus.control)
  );

  register_bank regs_inst (
    .clock, .reset, .rf(rf_bus.bank), .peek_sel, .peek_data
  );

  alu alu_inst (.au(alu_bus.unit));

endmodule

// ==== hdl/apb_host_port.sv ====
`timescale 1ns/10ps
`include "cpu_defs.svh"

module apb_host_port (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [`APB_ADDR_BITS-1:0]   paddr,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [`APB_DATA_BITS-1:0]   pwdata,
  output logic [`APB_DATA_BITS-1:0]   prdata,
  output logic                        pready,     // Zero wait states
  output logic                        pslverr,
  output logic                        imem_we,    // Program word write
  output logic [`IMEM_ADDR_BITS-1:0]  imem_waddr,
  output logic [`WORD_BITS-1:0]       imem_wdata,
  output logic                        start,      // Registered run pulse
  input  bus_pkg::status_t            status,
  output logic [`REG_ADDR_BITS-1:0]   peek_sel,   // Register to inspect
  input  logic [`WORD_BITS-1:0]       peek_data
);

  bus_pkg::region_e region;  // Decoded target
  logic             access;  // APB access phase

  // Address map decode, word aligned only
  always_comb begin
    if (!paddr[7] && paddr[1:0] == 2'b00) region = bus_pkg::IMEM;
    else if (paddr == 8'h80) region = bus_pkg::CTRL;
    else if (paddr[7:5] == 3'b101 && paddr[1:0] == 2'b00) region = bus_pkg::REGS;
    else region = bus_pkg::NONE;
  end

  assign access = psel && penable;

  assign imem_we    = access && pwrite && (region == bus_pkg::IMEM);
  assign imem_waddr = paddr[6:2];             // Word index
  assign imem_wdata = pwdata[`WORD_BITS-1:0]; // Upper bits ignored
  assign peek_sel   = paddr[4:2];             // Register index

  // Start pulse, one cycle after the CTRL write
  always_ff @(posedge clock) begin
    if (reset) start <= 1'b0;
    else start <= access && pwrite && (region == bus_pkg::CTRL) && pwdata[0];
  end

  // Read mux
  always_comb begin
    prdata = '0;
    if (region == bus_pkg::CTRL) prdata = {{(`APB_DATA_BITS-2){1'b0}}, status};
    else if (region == bus_pkg::REGS) prdata = {{(`APB_DATA_BITS-`WORD_BITS){1'b0}}, peek_data};
  end

  assign pready  = 1'b1;
  assign pslverr = access && ((region == bus_pkg::NONE) ||
                              (region == bus_pkg::IMEM && !pwrite));  // IMEM is write-only

  // Master must hold psel through the access phase
  a_penable_psel: assert property (
    @(posedge clock) disable iff (reset)
    penable |-> psel
  ) else $error("apb_host_port: penable without psel");

endmodule

// ==== hdl/control_unit.sv ====
`timescale 1ns/10ps
`include "cpu_defs.svh"

module control_unit (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        start,   // One-cycle pulse from host
  output bus_pkg::status_t            status,  // busy and done
  output logic [`IMEM_ADDR_BITS-1:0]  pc,      // Fetch address
  input  logic [`WORD_BITS-1:0]       instr,   // Word at pc
  regfile_if.control                  rf,      // Register bank access
  alu_if.control                      au       // Operation unit
);

  cpu_pkg::ctrl_state_e state;  // Sequencer state
  cpu_pkg::instr_t      ir;     // Instruction being executed
  logic                 done;   // Program finished, sticky
  logic                 is_data_op;
  logic                 last_step;

  // Only these opcodes write back a result
  assign is_data_op = ir.opcode inside {cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND,
                                        cpu_pkg::OR, cpu_pkg::XOR, cpu_pkg::MOV,
                                        cpu_pkg::LDI, cpu_pkg::SHL};

  // HALT, or the final memory word, ends the run
  assign last_step = (ir.opcode == cpu_pkg::HALT) || (pc == `IMEM_ADDR_BITS'(`IMEM_DEPTH - 1));

  // Sequencer, two cycles per instruction
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= cpu_pkg::IDLE;
      pc    <= '0;
      done  <= 1'b0;
    end else begin
      unique case (state)
        cpu_pkg::IDLE: begin
          if (start) begin         // Start while running never reaches here
            state <= cpu_pkg::FETCH;
            pc    <= '0;           // Always run from word 0
            done  <= 1'b0;
          end
        end
        cpu_pkg::FETCH: begin
          state <= cpu_pkg::EXEC;
        end
        cpu_pkg::EXEC: begin
          if (last_step) begin
            state <= cpu_pkg::IDLE;  // busy drops with done rising
            done  <= 1'b1;
          end else begin
            state <= cpu_pkg::FETCH;
            pc    <= pc + 1'b1;
          end
        end
        default: state <= cpu_pkg::IDLE;
      endcase
    end
  end

  // Instruction register, payload only
  always_ff @(posedge clock) begin
    if (state == cpu_pkg::FETCH) begin
      ir <= cpu_pkg::instr_t'(instr);
    end
  end

  assign status.busy = (state != cpu_pkg::IDLE);  // High from FETCH until stop
  assign status.done = done;

  // Decode of the held instruction
  assign rf.sel_e_sa     = ir.dst;   // Destination is also operand A
  assign rf.sel_sb       = ir.srcb;
  assign rf.e            = au.result;
  assign rf.write_enable = (state == cpu_pkg::EXEC) && is_data_op;

  assign au.op  = ir.opcode;
  assign au.a   = rf.a;
  assign au.b   = rf.b;
  assign au.imm = ir.imm;

  // A register write lands in the cycle right after its fetch
  a_we_in_exec: assert property (
    @(posedge clock) disable iff (reset)
    rf.write_enable |-> $past(state == cpu_pkg::FETCH)
  ) else $error("control_unit: write not preceded by FETCH");

endmodule

// ==== hdl/instr_store.sv ====
`timescale 1ns/10ps
`include "cpu_defs.svh"

module instr_store (
  input  logic                        clock,
  input  logic                        we,     // Host write strobe
  input  logic [`IMEM_ADDR_BITS-1:0]  waddr,  // Host word index
  input  logic [`WORD_BITS-1:0]       wdata,  // Instruction to store
  input  logic [`IMEM_ADDR_BITS-1:0]  raddr,  // Program counter
  output logic [`WORD_BITS-1:0]       rdata   // Instruction at pc
);

  logic [`WORD_BITS-1:0] mem [`IMEM_DEPTH];  // Program words, kept over reset

  // Host loads the program one word per APB write
  always_ff @(posedge clock) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  assign rdata = mem[raddr];  // Asynchronous fetch path

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/10ps
`include "cpu_defs.svh"

module alu (
  alu_if.unit au  // Operands in, result out
);

  // One result per data opcode
  always_comb begin
    unique case (au.op)
      cpu_pkg::ADD: au.result = au.a + au.b;  // Wraps at word width
      cpu_pkg::SUB: au.result = au.a - au.b;  // Wraps at word width
      cpu_pkg::AND: au.result = au.a & au.b;
      cpu_pkg::OR:  au.result = au.a | au.b;
      cpu_pkg::XOR: au.result = au.a ^ au.b;
      cpu_pkg::MOV: au.result = au.b;         // Copy B into destination
      cpu_pkg::LDI: begin
        au.result = {{(`WORD_BITS-6){1'b0}}, au.imm};  // Zero-extended
      end
      cpu_pkg::SHL: au.result = {au.a[`WORD_BITS-2:0], 1'b0};  // MSB drops out
      default: au.result = au.a;  // NOP, HALT, unused codes pass A
    endcase
  end

  // Every opcode value, listed or not, must give a defined result
  always_comb begin
    if (!$isunknown({au.op, au.a, au.b, au.imm})) begin
      a_result_known: assert (!$isunknown(au.result))
        else $error("alu: result unknown for op %h", au.op);
    end
  end

endmodule

// ==== hdl/register_bank.sv ====
`timescale 1ns/10ps
`include "cpu_defs.svh"

module register_bank (
  input  logic                       clock,
  input  logic                       reset,      // Clears all registers
  regfile_if.bank                    rf,         // Operand and write-back port
  input  logic [`REG_ADDR_BITS-1:0]  peek_sel,   // Inspection index from host
  output logic [`WORD_BITS-1:0]      peek_data   // Inspection data to host
);

  logic [`WORD_BITS-1:0] regs [`NUM_REGS];  // Register storage

  // Write port shares its address with read port A
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;  // All words back to zero
      end
    end else if (rf.write_enable) begin
      regs[rf.sel_e_sa] <= rf.e;  // Visible to reads next cycle
    end
  end

  // Reads are asynchronous, old value during a write
  assign rf.a      = regs[rf.sel_e_sa];  // Operand A, also destination
  assign rf.b      = regs[rf.sel_sb];    // Operand B
  assign peek_data = regs[peek_sel];     // Host inspection, no side effect

  // Control must always drive a clean strobe once out of reset
  a_we_known: assert property (
    @(posedge clock) disable iff (reset)
    !$isunknown(rf.write_enable)
  ) else $error("register_bank: write_enable unknown");

endmodule

// ==== hdl/cpu_ifs.sv ====
`timescale 1ns/10ps
`include "cpu_defs.svh"

// Control to register bank link
interface regfile_if;
  logic                       write_enable;  // Write e at rising edge
  logic [`REG_ADDR_BITS-1:0]  sel_e_sa;      // Write address and read port A
  logic [`REG_ADDR_BITS-1:0]  sel_sb;        // Read port B address
  logic [`WORD_BITS-1:0]      e;             // Write data
  logic [`WORD_BITS-1:0]      a;             // Operand A
  logic [`WORD_BITS-1:0]      b;             // Operand B

  modport control (output write_enable, sel_e_sa, sel_sb, e, input a, b);
  modport bank (input write_enable, sel_e_sa, sel_sb, e, output a, b);
endinterface

// Control to ALU link, purely combinational
interface alu_if;
  cpu_pkg::opcode_e       op;      // Operation select
  logic [`WORD_BITS-1:0]  a;       // Operand A
  logic [`WORD_BITS-1:0]  b;       // Operand B
  logic [5:0]             imm;     // Immediate for LDI
  logic [`WORD_BITS-1:0]  result;

  modport control (output op, a, b, imm, input result);
  modport unit (input op, a, b, imm, output result);
endinterface

// ==== hdl/bus_pkg.sv ====
package bus_pkg;

  // Decoded host address space
  typedef enum logic [1:0] {
    IMEM = 2'd0,  // 0x00..0x7C, word index in paddr[6:2]
    CTRL = 2'd1,  // 0x80, start on write, status on read
    REGS = 2'd2,  // 0xA0..0xBC, register index in paddr[4:2]
    NONE = 2'd3   // Anything else
  } region_e;

  // Status word seen at CTRL
  typedef struct packed {
    logic done;  // Bit 1, held until next start
    logic busy;  // Bit 0, program running
  } status_t;

endpackage

// ==== hdl/cpu_pkg.sv ====
`include "cpu_defs.svh"

package cpu_pkg;

  // Operation codes, unlisted values behave as NOP
  typedef enum logic [3:0] {
    NOP  = 4'd0,
    ADD  = 4'd1,  // dst = a + b
    SUB  = 4'd2,  // dst = a - b
    AND  = 4'd3,
    OR   = 4'd4,
    XOR  = 4'd5,
    MOV  = 4'd6,  // dst = b
    LDI  = 4'd7,  // dst = zero-extended imm
    SHL  = 4'd8,  // dst = a << 1
    HALT = 4'd15  // Stop and raise done
  } opcode_e;

  // Two-address instruction word
  typedef struct packed {
    opcode_e                    opcode;  // Bits 15..12
    logic [`REG_ADDR_BITS-1:0]  dst;     // Bits 11..9, also operand A
    logic [`REG_ADDR_BITS-1:0]  srcb;    // Bits 8..6
    logic [5:0]                 imm;     // Bits 5..0
  } instr_t;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,  // Waiting for start
    FETCH = 2'd1,  // Latch instruction
    EXEC  = 2'd2   // Decode, compute, write back
  } ctrl_state_e;

endpackage

// ==== include/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath sizes
`define WORD_BITS       16  // Data and instruction word
`define REG_ADDR_BITS   3   // Register index
`define NUM_REGS        8   // Registers in the bank

// Program memory
`define IMEM_ADDR_BITS  5   // Instruction word index
`define IMEM_DEPTH      32  // Instruction words

`define APB_ADDR_BITS   8   // Host byte address
`define APB_DATA_BITS   32  // Host data bus

`endif
